//--- Bender.yml
package:
  name: mem_route

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_route_pkg.sv
      - rtl/src_order_queue.sv
      - rtl/channel_steer.sv
      - rtl/access_stats.sv
      - rtl/mem_route_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_clock_gen.sv
      - test/mem_route_assert.sv
      - test/mem_route_checker.sv
      - test/mem_route_tb.sv

//--- files.f
+incdir+rtl
rtl/mem_route_pkg.sv
rtl/src_order_queue.sv
rtl/channel_steer.sv
rtl/access_stats.sv
rtl/mem_route_top.sv
test/tb_clock_gen.sv
test/mem_route_assert.sv
test/mem_route_checker.sv
test/mem_route_tb.sv

//--- rtl/access_stats.sv
`timescale 1ns/10ps

module access_stats import mem_route_pkg::*; (
    input  logic          aclk,
    input  logic          aresetn,
    input  logic          req,
    input  logic          addr_ok,
    input  logic          cached,
    input  logic          wr,
    output access_stats_t stats
);

    logic accept;

    // a data request counts once, on its accepted cycle
    assign accept = req && addr_ok;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stats <= '0;
        end else if (accept) begin
            case ({cached, wr})
                2'b11: begin
                    stats.cached_wr <= stats.cached_wr + 1'b1;
                end
                2'b10: begin
                    stats.cached_rd <= stats.cached_rd + 1'b1;
                end
                2'b01: begin
                    stats.uncached_wr <= stats.uncached_wr + 1'b1;
                end
                2'b00: begin
                    stats.uncached_rd <= stats.uncached_rd + 1'b1;
                end
            endcase
        end
    end

endmodule

//--- rtl/channel_steer.sv
`timescale 1ns/10ps

module channel_steer import mem_route_pkg::*; (
    input  logic  aclk,
    input  logic  aresetn,

    // processor side
    input  logic  req,
    input  logic  cached,
    output logic  addr_ok,
    output logic  data_ok,
    output word_t rdata,

    // path side
    output logic  cached_req,
    output logic  uncached_req,
    input  logic  cached_addr_ok,
    input  logic  uncached_addr_ok,
    input  logic  cached_data_ok,
    input  logic  uncached_data_ok,
    input  word_t cached_rdata,
    input  word_t uncached_rdata
);

    logic head_cached;
    logic q_empty;
    logic q_full;
    logic can_go;
    logic path_addr_ok;
    logic accept;

    // no path switch while the other path still owes responses
    assign can_go = !q_full && (q_empty || (head_cached == cached));

    // only the strobe is steered
    assign cached_req   = req && can_go && cached;
    assign uncached_req = req && can_go && !cached;

    assign path_addr_ok = cached ? cached_addr_ok : uncached_addr_ok;
    assign addr_ok      = can_go && path_addr_ok;
    assign accept       = req && addr_ok;

    // paths answer in order, so the head names the responder
    assign data_ok = cached_data_ok || uncached_data_ok;
    assign rdata   = head_cached ? cached_rdata : uncached_rdata;

    src_order_queue order_q (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .push        (accept),
        .push_cached (cached),
        .pop         (data_ok),
        .head_cached (head_cached),
        .empty       (q_empty),
        .full        (q_full)
    );

endmodule

//--- rtl/mem_route_macros.svh
`ifndef MEM_ROUTE_MACROS_SVH
`define MEM_ROUTE_MACROS_SVH

// request bus widths
`define MR_ADDR_W 32
`define MR_DATA_W 32
`define MR_STRB_W 4
`define MR_SIZE_W 2

// data access counters
`define MR_CNT_W 32

// outstanding requests per channel
`define MR_QUEUE_DEPTH 4
// index bits of the order queue, pointers carry one more
`define MR_PTR_W 2

`endif

//--- rtl/mem_route_pkg.sv
`include "mem_route_macros.svh"

package mem_route_pkg;

    typedef logic [`MR_ADDR_W-1:0] addr_t;
    typedef logic [`MR_DATA_W-1:0] word_t;
    typedef logic [`MR_STRB_W-1:0] strb_t;
    typedef logic [`MR_SIZE_W-1:0] size_t;
    typedef logic [`MR_CNT_W-1:0]  count_t;

    // data channel payload, same for both data paths
    typedef struct packed {
        logic  wr;
        size_t size;
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
    } data_req_t;

    // accepted data requests by path and direction
    typedef struct packed {
        count_t cached_wr;
        count_t cached_rd;
        count_t uncached_wr;
        count_t uncached_rd;
    } access_stats_t;

endpackage

//--- rtl/mem_route_top.sv
`timescale 1ns/10ps

module mem_route_top import mem_route_pkg::*; (
    input  logic          aclk,
    input  logic          aresetn,

    // instruction fetch port
    input  logic          inst_req,
    input  logic          inst_cached,
    input  addr_t         inst_addr,
    output logic          inst_addr_ok,
    output logic          inst_data_ok,
    output word_t         inst_rdata,

    // data port
    input  logic          data_req,
    input  logic          data_cached,
    input  data_req_t     data_bits,
    output logic          data_addr_ok,
    output logic          data_data_ok,
    output word_t         data_rdata,

    // cached instruction path
    output logic          icache_req,
    output addr_t         icache_addr,
    input  logic          icache_addr_ok,
    input  logic          icache_data_ok,
    input  word_t         icache_rdata,

    // uncached instruction path
    output logic          iuncache_req,
    output addr_t         iuncache_addr,
    input  logic          iuncache_addr_ok,
    input  logic          iuncache_data_ok,
    input  word_t         iuncache_rdata,

    // cached data path
    output logic          dcache_req,
    output data_req_t     dcache_bits,
    input  logic          dcache_addr_ok,
    input  logic          dcache_data_ok,
    input  word_t         dcache_rdata,

    // uncached data path
    output logic          duncache_req,
    output data_req_t     duncache_bits,
    input  logic          duncache_addr_ok,
    input  logic          duncache_data_ok,
    input  word_t         duncache_rdata,

    output access_stats_t stats
);

    // payload goes to both paths, req picks the one that acts
    assign icache_addr   = inst_addr;
    assign iuncache_addr = inst_addr;
    assign dcache_bits   = data_bits;
    assign duncache_bits = data_bits;

    channel_steer inst_steer (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .req              (inst_req),
        .cached           (inst_cached),
        .addr_ok          (inst_addr_ok),
        .data_ok          (inst_data_ok),
        .rdata            (inst_rdata),
        .cached_req       (icache_req),
        .uncached_req     (iuncache_req),
        .cached_addr_ok   (icache_addr_ok),
        .uncached_addr_ok (iuncache_addr_ok),
        .cached_data_ok   (icache_data_ok),
        .uncached_data_ok (iuncache_data_ok),
        .cached_rdata     (icache_rdata),
        .uncached_rdata   (iuncache_rdata)
    );

    channel_steer data_steer (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .req              (data_req),
        .cached           (data_cached),
        .addr_ok          (data_addr_ok),
        .data_ok          (data_data_ok),
        .rdata            (data_rdata),
        .cached_req       (dcache_req),
        .uncached_req     (duncache_req),
        .cached_addr_ok   (dcache_addr_ok),
        .uncached_addr_ok (duncache_addr_ok),
        .cached_data_ok   (dcache_data_ok),
        .uncached_data_ok (duncache_data_ok),
        .cached_rdata     (dcache_rdata),
        .uncached_rdata   (duncache_rdata)
    );

    // counts what the processor sees accepted
    access_stats stats_cnt (
        .aclk    (aclk),
        .aresetn (aresetn),
        .req     (data_req),
        .addr_ok (data_addr_ok),
        .cached  (data_cached),
        .wr      (data_bits.wr),
        .stats   (stats)
    );

endmodule

//--- rtl/src_order_queue.sv
`timescale 1ns/10ps
`include "mem_route_macros.svh"

module src_order_queue (
    input  logic aclk,
    input  logic aresetn,
    input  logic push,
    input  logic push_cached,
    input  logic pop,
    output logic head_cached,
    output logic empty,
    output logic full
);

    localparam int DEPTH = `MR_QUEUE_DEPTH;

    // one cached flag per outstanding request
    logic [DEPTH-1:0]   flags;
    logic [`MR_PTR_W:0] wr_ptr;
    logic [`MR_PTR_W:0] rd_ptr;
    logic               do_push;
    logic               do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge aclk) begin
        if (do_push) begin
            flags[wr_ptr[`MR_PTR_W-1:0]] <= push_cached;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // head leaves on the response
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign head_cached = flags[rd_ptr[`MR_PTR_W-1:0]];

    // same index, wrap bits tell empty from full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[`MR_PTR_W] != rd_ptr[`MR_PTR_W]) &&
                   (wr_ptr[`MR_PTR_W-1:0] == rd_ptr[`MR_PTR_W-1:0]);

endmodule

//--- test/mem_route_assert.sv
`timescale 1ns/10ps

module mem_route_assert (
    input logic aclk,
    input logic aresetn,
    input logic req,
    input logic cached,
    input logic addr_ok,
    input logic data_ok,
    input logic cached_req,
    input logic uncached_req,
    input logic head_cached,
    input logic q_empty,
    input logic q_full
);

    int fail_count = 0;

    // other path still owes responses, so nothing may leave
    no_path_switch: assert property (@(posedge aclk) disable iff (!aresetn)
        (req && !q_empty && (head_cached != cached)) |->
            !(cached_req || uncached_req || addr_ok))
        else begin
            $error("path switch let through with responses outstanding");
            fail_count++;
        end

    full_blocks: assert property (@(posedge aclk) disable iff (!aresetn)
        q_full |-> !(addr_ok || cached_req || uncached_req))
        else begin
            $error("request let through while the order queue is full");
            fail_count++;
        end

    // a response needs a recorded request
    no_orphan_response: assert property (@(posedge aclk) disable iff (!aresetn)
        data_ok |-> !q_empty)
        else begin
            $error("data_ok with no request recorded in the order queue");
            fail_count++;
        end

    // head entry only moves on a response
    head_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (!q_empty && !data_ok) |=> $stable(head_cached))
        else begin
            $error("order queue head changed without a response");
            fail_count++;
        end

endmodule

bind channel_steer mem_route_assert steer_assert (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .req          (req),
    .cached       (cached),
    .addr_ok      (addr_ok),
    .data_ok      (data_ok),
    .cached_req   (cached_req),
    .uncached_req (uncached_req),
    .head_cached  (head_cached),
    .q_empty      (q_empty),
    .q_full       (q_full)
);

//--- test/mem_route_checker.sv
`timescale 1ns/10ps
`include "mem_route_macros.svh"

module mem_route_checker import mem_route_pkg::*; (
    input  logic          aclk,
    input  logic          aresetn,
    input  logic          inst_req,
    input  logic          inst_cached,
    input  addr_t         inst_addr,
    input  logic          inst_addr_ok,
    input  logic          inst_data_ok,
    input  word_t         inst_rdata,
    input  logic          data_req,
    input  logic          data_cached,
    input  data_req_t     data_bits,
    input  logic          data_addr_ok,
    input  logic          data_data_ok,
    input  word_t         data_rdata,
    input  logic          icache_req,
    input  logic          iuncache_req,
    input  logic          dcache_req,
    input  logic          duncache_req,
    input  addr_t         icache_addr,
    input  addr_t         iuncache_addr,
    input  data_req_t     dcache_bits,
    input  data_req_t     duncache_bits,
    input  access_stats_t stats,
    input  int            assert_errors,
    output int            error_count
);

    // bit 32 set when rdata must be compared
    logic [32:0] exp_inst_q[$];
    logic [32:0] exp_data_q[$];
    int          outstanding[2];
    logic        out_path[2];
    access_stats_t exp_stats;
    int          mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    initial begin
        error_count = 0;
        outstanding[0] = 0;
        outstanding[1] = 0;
        exp_stats = '0;
    end

    task automatic note_failure(input string msg);
        $display("%0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic flag_value(input string name, input word_t exp, input word_t act);
        $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
        error_count++;
    endtask

    task automatic flag_payload(input string name, input data_req_t exp,
                                input data_req_t act);
        $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
        error_count++;
    endtask

    function automatic int total_errors();
        return error_count + assert_errors;
    endfunction

    // called by the testbench on each accepted request
    task automatic expect_push(input int ch, input logic cached, input logic wr,
                               input word_t value);
        if (ch == 0) begin
            exp_inst_q.push_back({!wr, value});
        end else begin
            exp_data_q.push_back({!wr, value});
            case ({cached, wr})
                2'b11: exp_stats.cached_wr++;
                2'b10: exp_stats.cached_rd++;
                2'b01: exp_stats.uncached_wr++;
                default: exp_stats.uncached_rd++;
            endcase
        end
    endtask

    function automatic int pending(input int ch);
        return (ch == 0) ? exp_inst_q.size() : exp_data_q.size();
    endfunction

    task automatic check_channel(input int ch, input string name, input logic req,
                                 input logic cached, input logic addr_ok,
                                 input logic data_ok, input word_t rdata,
                                 input logic path_req);
        logic [32:0] entry;
        logic        accept;
        accept = req && addr_ok;
        if (req && outstanding[ch] > 0 && cached != out_path[ch] && (path_req || addr_ok)) begin
            note_failure({name, " request let through while the other path owed responses"});
        end
        if (accept && outstanding[ch] >= `MR_QUEUE_DEPTH) begin
            note_failure({name, " accepted more requests than the queue holds"});
        end
        if (data_ok) begin
            if (pending(ch) == 0) begin
                note_failure({name, " data_ok with no request outstanding"});
            end else begin
                if (ch == 0) begin
                    entry = exp_inst_q.pop_front();
                end else begin
                    entry = exp_data_q.pop_front();
                end
                if (entry[32] && rdata !== entry[31:0]) begin
                    flag_value({name, "_rdata"}, entry[31:0], rdata);
                end
            end
            outstanding[ch]--;
        end
        if (accept) begin
            outstanding[ch]++;
            out_path[ch] = cached;
        end
    endtask

    always @(posedge aclk) begin
        if (aresetn) begin
            check_channel(0, "inst", inst_req, inst_cached, inst_addr_ok, inst_data_ok,
                          inst_rdata, icache_req || iuncache_req);
            check_channel(1, "data", data_req, data_cached, data_addr_ok, data_data_ok,
                          data_rdata, dcache_req || duncache_req);
        end
    end

    // both paths of a channel see the processor payload unchanged
    always @(posedge aclk) begin
        if (aresetn) begin
            if (icache_addr !== inst_addr) begin
                flag_value("icache_addr", inst_addr, icache_addr);
            end
            if (iuncache_addr !== inst_addr) begin
                flag_value("iuncache_addr", inst_addr, iuncache_addr);
            end
            if (dcache_bits !== data_bits) begin
                flag_payload("dcache_bits", data_bits, dcache_bits);
            end
            if (duncache_bits !== data_bits) begin
                flag_payload("duncache_bits", data_bits, duncache_bits);
            end
        end
    end

    task automatic check_idle();
        if (icache_req || iuncache_req || dcache_req || duncache_req) begin
            note_failure("path req high before any request");
        end
        if (inst_data_ok || data_data_ok) begin
            note_failure("data_ok high before any request");
        end
        // no request yet, so every counter expects zero
        check_stats();
    endtask

    task automatic check_stats();
        if (stats.cached_wr !== exp_stats.cached_wr) begin
            flag_value("stats.cached_wr", exp_stats.cached_wr, stats.cached_wr);
        end
        if (stats.cached_rd !== exp_stats.cached_rd) begin
            flag_value("stats.cached_rd", exp_stats.cached_rd, stats.cached_rd);
        end
        if (stats.uncached_wr !== exp_stats.uncached_wr) begin
            flag_value("stats.uncached_wr", exp_stats.uncached_wr, stats.uncached_wr);
        end
        if (stats.uncached_rd !== exp_stats.uncached_rd) begin
            flag_value("stats.uncached_rd", exp_stats.uncached_rd, stats.uncached_rd);
        end
    endtask

    task automatic report_test(input int id, input string name);
        int errs;
        errs = total_errors() - mark;
        mark = total_errors();
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s (%0d errors)", id, name, (errs == 0) ? "ok" : "FAIL", errs);
    endtask

    task automatic finish_summary();
        $display("tests run %0d, tests failing %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
    endtask

endmodule

//--- test/mem_route_tb.sv
`timescale 1ns/10ps

// path model, accepts after 0 to 3 cycles and answers in order
module path_responder import mem_route_pkg::*; #(
    parameter bit CACHED = 1'b1,
    parameter int ID     = 0
) (
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  req,
    input  addr_t addr,
    input  logic  hold,
    output logic  addr_ok,
    output logic  data_ok,
    output word_t rdata
);

    addr_t       addr_q[$];
    int          lat_q[$];
    int          gap;
    logic [31:0] seed;
    logic        take;
    logic        hold_now;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t answer(input addr_t a);
        return CACHED ? (a ^ 32'h5a5a5a5a) : ~a;
    endfunction

    initial begin
        seed = lcg_next(32'h0bfa048b ^ ID);
        gap = 0;
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata = '0;
    end

    always @(posedge aclk) begin
        if (!aresetn) begin
            addr_q.delete();
            lat_q.delete();
            gap = 0;
            #1;
            addr_ok = 1'b0;
            data_ok = 1'b0;
        end else begin
            take = req && addr_ok;
            hold_now = hold;
            if (data_ok) begin
                void'(addr_q.pop_front());
                void'(lat_q.pop_front());
            end
            if (take) begin
                addr_q.push_back(addr);
                seed = lcg_next(seed);
                lat_q.push_back(1 + seed[17:16]);
                seed = lcg_next(seed);
                gap = seed[17:16];
            end else if (gap > 0) begin
                gap--;
            end
            if (lat_q.size() > 0 && lat_q[0] > 0) begin
                lat_q[0]--;
            end
            #1;
            addr_ok = (gap == 0);
            if (lat_q.size() > 0 && lat_q[0] == 0 && !hold_now) begin
                data_ok = 1'b1;
                rdata = answer(addr_q[0]);
            end else begin
                data_ok = 1'b0;
            end
        end
    end

endmodule

module mem_route_tb import mem_route_pkg::*; ();

    localparam int ACCEPT_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT  = 100;
    localparam int MAX_CASES      = 64;

    logic aclk, aresetn, hold;
    logic inst_req, inst_cached, inst_addr_ok, inst_data_ok;
    logic data_req, data_cached, data_addr_ok, data_data_ok;
    addr_t inst_addr, icache_addr, iuncache_addr;
    word_t inst_rdata, data_rdata;
    data_req_t data_bits, dcache_bits, duncache_bits;
    logic icache_req, icache_addr_ok, icache_data_ok;
    logic iuncache_req, iuncache_addr_ok, iuncache_data_ok;
    logic dcache_req, dcache_addr_ok, dcache_data_ok;
    logic duncache_req, duncache_addr_ok, duncache_data_ok;
    word_t icache_rdata, iuncache_rdata, dcache_rdata, duncache_rdata;
    access_stats_t stats;
    int error_count;
    int assert_errors;

    int    case_test[MAX_CASES];
    int    case_ch[MAX_CASES];
    logic  case_cached[MAX_CASES];
    logic  case_wr[MAX_CASES];
    addr_t case_addr[MAX_CASES];
    word_t case_wdata[MAX_CASES];
    word_t case_expect[MAX_CASES];
    int    n_cases = 0;

    tb_clock_gen clock_gen (.aclk(aclk), .aresetn(aresetn));

    mem_route_top mem_route_top_inst (.*);

    path_responder #(.CACHED(1'b1), .ID(0)) icache_model (
        .aclk(aclk), .aresetn(aresetn), .req(icache_req), .addr(icache_addr), .hold(hold),
        .addr_ok(icache_addr_ok), .data_ok(icache_data_ok), .rdata(icache_rdata));
    path_responder #(.CACHED(1'b0), .ID(1)) iuncache_model (
        .aclk(aclk), .aresetn(aresetn), .req(iuncache_req), .addr(iuncache_addr), .hold(hold),
        .addr_ok(iuncache_addr_ok), .data_ok(iuncache_data_ok), .rdata(iuncache_rdata));
    path_responder #(.CACHED(1'b1), .ID(2)) dcache_model (
        .aclk(aclk), .aresetn(aresetn), .req(dcache_req), .addr(dcache_bits.addr), .hold(hold),
        .addr_ok(dcache_addr_ok), .data_ok(dcache_data_ok), .rdata(dcache_rdata));
    path_responder #(.CACHED(1'b0), .ID(3)) duncache_model (
        .aclk(aclk), .aresetn(aresetn), .req(duncache_req), .addr(duncache_bits.addr),
        .hold(hold), .addr_ok(duncache_addr_ok), .data_ok(duncache_data_ok),
        .rdata(duncache_rdata));

    assign assert_errors = mem_route_top_inst.inst_steer.steer_assert.fail_count +
                           mem_route_top_inst.data_steer.steer_assert.fail_count;

    mem_route_checker route_check (.*);

    task automatic abort_run(input string msg);
        $display("%0t ns: %s", $time, msg);
        route_check.finish_summary();
        $display("test failed");
        $finish;
    endtask

    task automatic read_cases();
        int    fd;
        int    n;
        int    t, c, ca, w;
        addr_t a;
        word_t d, e;
        string line;
        fd = $fopen("test/route_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open test/route_cases.txt");
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %d %h %h %h", t, c, ca, w, a, d, e);
                    if (n == 7) begin
                        case_test[n_cases] = t;
                        case_ch[n_cases] = c;
                        case_cached[n_cases] = ca[0];
                        case_wr[n_cases] = w[0];
                        case_addr[n_cases] = a;
                        case_wdata[n_cases] = d;
                        case_expect[n_cases] = e;
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_req(input int i);
        if (case_ch[i] == 0) begin
            data_req = 1'b0;
            inst_req = 1'b1;
            inst_cached = case_cached[i];
            inst_addr = case_addr[i];
        end else begin
            inst_req = 1'b0;
            data_req = 1'b1;
            data_cached = case_cached[i];
            data_bits = '{wr: case_wr[i], size: 2'b10, addr: case_addr[i],
                          wdata: case_wdata[i], wstrb: case_wr[i] ? 4'hf : 4'h0};
        end
    endtask

    function automatic logic accepted(input int ch);
        return (ch == 0) ? (inst_req && inst_addr_ok) : (data_req && data_addr_ok);
    endfunction

    task automatic wait_accept(input int i);
        int   cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge aclk);
            if (accepted(case_ch[i])) begin
                route_check.expect_push(case_ch[i], case_cached[i], case_wr[i], case_expect[i]);
                done = 1'b1;
            end else begin
                cycles++;
                if (cycles >= ACCEPT_TIMEOUT) begin
                    abort_run("timeout waiting for addr_ok");
                end
            end
        end
    endtask

    // fifth request with responders silent must wait
    task automatic send_blocked(input int i);
        logic early;
        early = 1'b0;
        #1 drive_req(i);
        repeat (12) begin
            @(posedge aclk);
            if (!early && accepted(case_ch[i])) begin
                route_check.note_failure("request accepted with four responses outstanding");
                route_check.expect_push(case_ch[i], case_cached[i], case_wr[i], case_expect[i]);
                early = 1'b1;
            end
        end
        #1 hold = 1'b0;
        if (!early) begin
            wait_accept(i);
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        #1;
        inst_req = 1'b0;
        data_req = 1'b0;
        while (route_check.pending(0) != 0 || route_check.pending(1) != 0) begin
            @(posedge aclk);
            cycles++;
            if (cycles >= DRAIN_TIMEOUT) begin
                abort_run("timeout waiting for outstanding responses");
            end
        end
    endtask

    task automatic run_test(input int id);
        int sent[2];
        sent[0] = 0;
        sent[1] = 0;
        for (int i = 0; i < n_cases; i++) begin
            if (case_test[i] == id) begin
                if (id == 4 && sent[case_ch[i]] == 4) begin
                    send_blocked(i);
                    drain();
                    #1 hold = 1'b1;
                end else begin
                    #1 drive_req(i);
                    wait_accept(i);
                end
                sent[case_ch[i]]++;
            end
        end
        drain();
    endtask

    initial begin
        int cycles;
        hold = 1'b0;
        inst_req = 1'b0;
        inst_cached = 1'b0;
        inst_addr = '0;
        data_req = 1'b0;
        data_cached = 1'b0;
        data_bits = '0;
        read_cases();
        cycles = 0;
        while (aresetn !== 1'b1) begin
            @(posedge aclk);
            cycles++;
            if (cycles > 20) begin
                abort_run("reset never released");
            end
        end
        repeat (4) begin
            @(posedge aclk);
            route_check.check_idle();
        end
        route_check.report_test(1, "reset idle");
        run_test(2);
        route_check.report_test(2, "mixed reads in order");
        run_test(3);
        route_check.report_test(3, "path switch held");
        #1 hold = 1'b1;
        run_test(4);
        route_check.report_test(4, "queue depth limit");
        @(posedge aclk);
        route_check.check_stats();
        route_check.report_test(5, "data access counters");
        route_check.finish_summary();
        if (error_count == 0 && assert_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- test/route_cases.txt
# test channel(0 inst, 1 data) cached wr addr wdata expected_rdata
# expected_rdata is ignored for writes
2 0 1 0 00001000 00000000 5a5a4a5a
2 0 1 0 00001004 00000000 5a5a4a5e
2 0 0 0 1fc00000 00000000 e03fffff
2 0 0 0 1fc00004 00000000 e03ffffb
2 0 1 0 00001008 00000000 5a5a4a52
2 1 1 0 00002000 00000000 5a5a7a5a
2 1 0 0 1faf0000 00000000 e050ffff
2 1 1 0 00002010 00000000 5a5a7a4a
2 1 0 0 1faf0010 00000000 e050ffef
3 0 0 0 bfc00100 00000000 403ffeff
3 0 1 0 00001100 00000000 5a5a4b5a
3 0 0 0 bfc00104 00000000 403ffefb
3 1 1 1 00003000 11223344 00000000
3 1 0 1 1faf0020 55667788 00000000
3 1 1 0 00003000 00000000 5a5a6a5a
3 1 0 1 1faf0024 aabbccdd 00000000
3 1 0 0 1faf0024 00000000 e050ffdb
3 1 1 1 00003004 0badf00d 00000000
4 0 1 0 00004000 00000000 5a5a1a5a
4 0 1 0 00004004 00000000 5a5a1a5e
4 0 1 0 00004008 00000000 5a5a1a52
4 0 1 0 0000400c 00000000 5a5a1a56
4 0 1 0 00004010 00000000 5a5a1a4a
4 1 0 0 1faf0100 00000000 e050feff
4 1 0 0 1faf0104 00000000 e050fefb
4 1 0 0 1faf0108 00000000 e050fef7
4 1 0 0 1faf010c 00000000 e050fef3
4 1 0 0 1faf0110 00000000 e050feef

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic aclk,
    output logic aresetn
);

    // 4 ns period
    initial begin
        aclk = 1'b0;
        forever begin
            #2 aclk = ~aclk;
        end
    end

    // reset held low for three rising edges
    initial begin
        aresetn = 1'b0;
        repeat (3) @(posedge aclk);
        #1 aresetn = 1'b1;
    end

endmodule
